/* verilog.f */
+incdir+design
design/eeprom_pkg.sv
design/i2c_op_if.sv
design/eeprom_cmd_sequencer.sv
design/i2c_byte_engine.sv
design/eeprom_result.sv
design/eeprom_wr.sv
test/i2c_eeprom_model.sv
test/tb_eeprom_wr.sv

/* Makefile */
# Verilator build and run for the serial EEPROM controller

VERILATOR ?= verilator
TOP       ?= tb_eeprom_wr
LOG       ?= sim.log
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP LOG FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_eeprom_wr.sv */
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module tb_eeprom_wr
    import eeprom_pkg::*;
();

    localparam int LIMIT = 220 * 50 * 4 * `QUARTER_CYCLES;

    logic  CLK;
    logic  RESET;
    logic  wr;
    logic  rd;
    addr_t addr;
    byte_t wdata;
    byte_t rdata;
    logic  ack;
    logic  nack_err;
    logic  scl;
    logic  sda_pull;
    logic  sda_in;
    logic  mute;
    logic  model_pull;

    byte_t shadow [0:2047];  // expected memory contents
    addr_t written [$];
    string cur_name;
    byte_t exp_rdata;
    logic  exp_nack;
    logic  exp_read;
    int    req_cnt = 0;
    int    ack_cnt = 0;
    int    checks = 0;
    int    mismatches = 0;
    int    cycles = 0;
    logic  reset_seen = 1'b0;

    assign sda_in = ~(sda_pull | model_pull);  // open drain, wired AND

    eeprom_wr u_eeprom_wr (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .ack      (ack),
        .nack_err (nack_err),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda_in)
    );

    i2c_eeprom_model u_model (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl      (scl),
        .sda      (sda_in),
        .mute     (mute),
        .sda_pull (model_pull)
    );

    always #4 CLK = ~CLK;

    function automatic byte_t ref_read(input addr_t a);
        return shadow[a];
    endfunction

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic print_summary();
        $display("checks %0d, mismatches %0d, acks %0d for %0d requests",
                 checks, mismatches, ack_cnt, req_cnt);
    endtask

    // one request, expectations set before it goes out
    task automatic request(input string name, input logic w, input logic r,
                           input addr_t a, input byte_t d);
        @(negedge CLK);
        cur_name  = name;
        exp_read  = !w && r;
        exp_nack  = mute;
        exp_rdata = ref_read(a);
        if (w && !mute)
            shadow[a] = d;
        wr    = w;
        rd    = r;
        addr  = a;
        wdata = d;
        req_cnt++;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        while (ack !== 1'b1)
            @(negedge CLK);
    endtask

    // compare process
    always @(posedge CLK) begin
        if (!RESET && !reset_seen) begin
            reset_seen <= 1'b1;
            check_flag("reset scl", 1'b1, scl);
            check_flag("reset sda_pull", 1'b0, sda_pull);
            check_flag("reset ack", 1'b0, ack);
            check_flag("reset nack_err", 1'b0, nack_err);
            check_byte("reset rdata", 8'h00, rdata);
        end
        if (!RESET && ack) begin
            ack_cnt++;
            check_flag({cur_name, " nack_err"}, exp_nack, nack_err);
            check_flag({cur_name, " scl released"}, 1'b1, scl);
            check_flag({cur_name, " sda released"}, 1'b0, sda_pull);
            if (exp_read)
                check_byte({cur_name, " rdata"}, exp_rdata, rdata);
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("ack never arrived, run stopped after %0d cycles", LIMIT);
            print_summary();
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        addr_t a;
        byte_t d;
        void'($urandom(32'h6683));
        CLK   = 1'b0;
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        mute  = 1'b0;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'hFF;
        repeat (2) @(negedge CLK);
        RESET = 1'b0;

        request("basic write", 1'b1, 1'b0, 11'h123, 8'h5A);
        request("basic read", 1'b0, 1'b1, 11'h123, 8'h00);
        request("unwritten read", 1'b0, 1'b1, 11'h6E1, 8'h00);

        for (int i = 0; i < 200; i++) begin
            if (written.size() == 0 || $urandom_range(0, 1) == 0) begin
                a = {3'(i), 8'($urandom)};  // walk all blocks
                d = 8'($urandom);
                written.push_back(a);
                request($sformatf("random write %0d", i), 1'b1, 1'b0, a, d);
            end else begin
                a = written[$urandom_range(0, written.size() - 1)];
                request($sformatf("random read %0d", i), 1'b0, 1'b1, a, 8'h00);
            end
        end

        request("mute setup write", 1'b1, 1'b0, 11'h2B4, 8'h3C);
        mute = 1'b1;
        request("muted write", 1'b1, 1'b0, 11'h2B4, 8'hC3);
        mute = 1'b0;
        request("read after mute", 1'b0, 1'b1, 11'h2B4, 8'h00);

        request("write priority", 1'b1, 1'b1, 11'h555, 8'hA7);
        request("read after priority", 1'b0, 1'b1, 11'h555, 8'h00);

        @(negedge CLK);
        if (ack_cnt != req_cnt)
            $display("ack count does not match the number of requests");
        print_summary();
        if (mismatches == 0 && ack_cnt == req_cnt) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* test/i2c_eeprom_model.sv */
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module i2c_eeprom_model
    import eeprom_pkg::*;
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic mute,      // high: acknowledge nothing
    output logic sda_pull
);

    byte_t      mem [0:2047];
    logic       scl_q;
    logic       sda_q;
    logic       active;
    logic       selected;
    logic       reading;
    logic [3:0] bit_cnt;    // 8 after last data bit, 9 after ack slot
    logic [1:0] byte_idx;   // stops at 2, data bytes
    logic [2:0] block;
    byte_t      ptr;
    byte_t      sh;
    byte_t      tx;
    ctrl_byte_u ctrl;

    // oversampled bus, edges seen one CLK late
    always @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < 2048; i++)
                mem[i] = 8'hFF;
            scl_q    = 1'b1;
            sda_q    = 1'b1;
            active   = 1'b0;
            selected = 1'b0;
            reading  = 1'b0;
            bit_cnt  = 4'd0;
            byte_idx = 2'd0;
            sda_pull <= 1'b0;
        end else begin
            if (scl_q && scl && sda_q && !sda) begin  // start or repeated start
                active   = 1'b1;
                selected = 1'b0;
                reading  = 1'b0;
                bit_cnt  = 4'd0;
                byte_idx = 2'd0;
                sda_pull <= 1'b0;
            end else if (scl_q && scl && !sda_q && sda) begin  // stop
                active = 1'b0;
                sda_pull <= 1'b0;
            end else if (active && !scl_q && scl) begin
                if (bit_cnt < 4'd8) begin
                    if (!reading)
                        sh = {sh[6:0], sda};
                end else if (reading && sda && byte_idx != 2'd0) begin
                    selected = 1'b0;  // master no-ack ends the read
                end
                bit_cnt = bit_cnt + 4'd1;
            end else if (active && scl_q && !scl) begin
                if (bit_cnt == 4'd8) begin
                    if (reading) begin
                        sda_pull <= 1'b0;  // master answers this one
                    end else begin
                        case (byte_idx)
                            2'd0: begin
                                ctrl.raw = sh;
                                selected = (ctrl.fields.dev_code == `EEPROM_DEV_CODE) && !mute;
                                block    = ctrl.fields.block;
                                reading  = ctrl.fields.rd_flag && selected;
                            end
                            2'd1: begin
                                if (selected)
                                    ptr = sh;
                            end
                            default: begin
                                if (selected) begin
                                    mem[{block, ptr}] = sh;
                                    ptr = ptr + 8'd1;
                                end
                            end
                        endcase
                        sda_pull <= selected;
                    end
                end else if (bit_cnt == 4'd9) begin
                    bit_cnt = 4'd0;
                    if (byte_idx != 2'd2)
                        byte_idx = byte_idx + 2'd1;
                    if (reading && selected) begin
                        tx  = mem[{block, ptr}];
                        ptr = ptr + 8'd1;
                        sda_pull <= ~tx[7];
                    end else begin
                        sda_pull <= 1'b0;
                    end
                end else if (reading && selected && bit_cnt != 4'd0) begin
                    sda_pull <= ~tx[3'(4'd7 - bit_cnt)];
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

/* design/eeprom_wr.sv */
`timescale 1ns/1ps

module eeprom_wr
    import eeprom_pkg::*;
(
    input  logic  CLK,
    input  logic  RESET,
    input  logic  wr,
    input  logic  rd,
    input  addr_t addr,
    input  byte_t wdata,
    output byte_t rdata,
    output logic  ack,
    output logic  nack_err,
    output logic  scl,
    output logic  sda_pull,     // open drain, high pulls SDA low
    input  logic  sda_in
);

    logic txn_end;
    logic read_txn;

    i2c_op_if op_bus ();

    eeprom_cmd_sequencer u_seq (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .op       (op_bus.seq),
        .txn_end  (txn_end),
        .read_txn (read_txn)
    );

    i2c_byte_engine u_eng (
        .CLK      (CLK),
        .RESET    (RESET),
        .op       (op_bus.eng),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda_in)
    );

    eeprom_result u_res (
        .CLK      (CLK),
        .RESET    (RESET),
        .op       (op_bus.res),
        .txn_end  (txn_end),
        .read_txn (read_txn),
        .rdata    (rdata),
        .ack      (ack),
        .nack_err (nack_err)
    );

endmodule

/* design/eeprom_result.sv */
`timescale 1ns/1ps

module eeprom_result
    import eeprom_pkg::*;
(
    input  logic  CLK,
    input  logic  RESET,
    i2c_op_if.res op,
    input  logic  txn_end,
    input  logic  read_txn,
    output byte_t rdata,
    output logic  ack,
    output logic  nack_err
);

    byte_t rx_sh;
    logic  nack_seen;  // sticky over the transaction

    always_ff @(posedge CLK) begin
        if (op.rx_bit_valid)
            rx_sh <= {rx_sh[6:0], op.rx_bit};
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            rdata     <= '0;
            ack       <= 1'b0;
            nack_err  <= 1'b0;
            nack_seen <= 1'b0;
        end else begin
            ack <= txn_end;
            if (txn_end) begin
                nack_err  <= nack_seen;
                nack_seen <= 1'b0;
                if (read_txn)
                    rdata <= rx_sh;
            end else if (op.op_done && op.slave_nack) begin
                nack_seen <= 1'b1;
            end
        end
    end

endmodule

/* design/i2c_byte_engine.sv */
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module i2c_byte_engine
    import eeprom_pkg::*;
(
    input  logic  CLK,
    input  logic  RESET,
    i2c_op_if.eng op,
    output logic  scl,
    output logic  sda_pull,
    input  logic  sda_in
);

    localparam int QC = `QUARTER_CYCLES;
    localparam int QW = $clog2(QC + 1);

    logic          busy;
    logic          accept;
    i2c_op_e       cur_op;
    byte_t         sh;          // transmit shift register
    logic          nack_bit;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;       // quarter within the bit
    logic [3:0]    bcnt;        // 0..7 data, 8 ack
    logic          tick;
    logic          sample;
    logic          ack_bit;
    logic          last_bit;
    logic          scl_d;
    logic          pull_d;

    assign op.op_ready = ~busy;
    assign accept      = op.op_valid && ~busy;
    assign tick        = (qcnt == QW'(QC - 1));
    assign sample      = busy && (phase == 2'd2) && (qcnt == '0);  // middle of SCL high
    assign ack_bit     = (bcnt == 4'd8);
    assign last_bit    = (cur_op == op_start) || (cur_op == op_stop) || ack_bit;

    // bus levels for the current quarter, registered below
    always_comb begin
        scl_d  = scl;
        pull_d = sda_pull;
        if (busy) begin
            case (cur_op)
                op_start: begin
                    // q0 keeps scl, so idle and repeated start share one pattern
                    scl_d  = (phase == 2'd0) ? scl : (phase != 2'd3);
                    pull_d = phase[1];  // SDA falls while SCL high
                end
                op_stop: begin
                    scl_d  = (phase != 2'd0);
                    pull_d = ~phase[1];  // SDA rises while SCL high
                end
                default: begin
                    scl_d = (phase == 2'd1) || (phase == 2'd2);
                    if (ack_bit)
                        pull_d = (cur_op == op_read) && ~nack_bit;
                    else
                        pull_d = (cur_op == op_write) && ~sh[7];
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy            <= 1'b0;
            qcnt            <= '0;
            phase           <= 2'd0;
            bcnt            <= 4'd0;
            scl             <= 1'b1;
            sda_pull        <= 1'b0;
            op.op_done      <= 1'b0;
            op.slave_nack   <= 1'b0;
            op.rx_bit_valid <= 1'b0;
        end else begin
            scl             <= scl_d;
            sda_pull        <= pull_d;
            op.op_done      <= 1'b0;
            op.rx_bit_valid <= sample && (cur_op == op_read) && ~ack_bit;

            if (accept) begin
                busy          <= 1'b1;
                qcnt          <= '0;
                phase         <= 2'd0;
                bcnt          <= 4'd0;
                op.slave_nack <= 1'b0;
            end else if (busy) begin
                if (sample && ack_bit && cur_op == op_write)
                    op.slave_nack <= sda_in;  // high = no ack
                if (tick) begin
                    qcnt  <= '0;
                    phase <= phase + 2'd1;
                    if (phase == 2'd3) begin
                        if (last_bit) begin
                            busy       <= 1'b0;
                            op.op_done <= 1'b1;
                        end else begin
                            bcnt <= bcnt + 4'd1;
                        end
                    end
                end else begin
                    qcnt <= qcnt + QW'(1);
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            cur_op   <= op.op;
            sh       <= op.tx_byte;
            nack_bit <= op.send_nack;
        end else if (busy && tick && phase == 2'd3) begin
            sh <= {sh[6:0], 1'b0};  // next bit, msb first
        end
        if (sample)
            op.rx_bit <= sda_in;
    end

endmodule

/* design/eeprom_cmd_sequencer.sv */
`timescale 1ns/1ps
`include "eeprom_macros.svh"

module eeprom_cmd_sequencer
    import eeprom_pkg::*;
(
    input  logic  CLK,
    input  logic  RESET,
    input  logic  wr,
    input  logic  rd,
    input  addr_t addr,
    input  byte_t wdata,
    i2c_op_if.seq op,
    output logic  txn_end,
    output logic  read_txn
);

    localparam logic [8:0] S_IDLE   = 9'b0_0000_0001;
    localparam logic [8:0] S_START  = 9'b0_0000_0010;
    localparam logic [8:0] S_CTRL_W = 9'b0_0000_0100;
    localparam logic [8:0] S_ADDR   = 9'b0_0000_1000;
    localparam logic [8:0] S_DATA   = 9'b0_0001_0000;
    localparam logic [8:0] S_RSTART = 9'b0_0010_0000;
    localparam logic [8:0] S_CTRL_R = 9'b0_0100_0000;
    localparam logic [8:0] S_READ   = 9'b0_1000_0000;
    localparam logic [8:0] S_STOP   = 9'b1_0000_0000;

    logic [8:0] state;
    logic       issued;     // current op handed to engine, waiting for done
    logic       accept;
    ctrl_byte_u ctrl;
    byte_t      word_addr;
    byte_t      data;

    assign accept = (state == S_IDLE) && (wr || rd);

    assign op.op_valid  = ~state[0] & ~issued;
    assign op.send_nack = (state == S_READ);  // single byte read ends with no-ack
    assign txn_end      = (state == S_STOP) && op.op_done;

    always_comb begin
        op.op      = op_write;
        op.tx_byte = ctrl.raw;
        case (state)
            S_START, S_RSTART: op.op = op_start;
            S_ADDR:            op.tx_byte = word_addr;
            S_DATA:            op.tx_byte = data;
            S_READ:            op.op = op_read;
            S_STOP:            op.op = op_stop;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= S_IDLE;
            issued   <= 1'b0;
            read_txn <= 1'b0;
        end else begin
            if (op.op_valid && op.op_ready)
                issued <= 1'b1;
            if (op.op_done)
                issued <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (accept) begin
                        read_txn <= ~wr;  // write wins a tie
                        state    <= S_START;
                    end
                end
                S_START: begin
                    if (op.op_done)
                        state <= S_CTRL_W;
                end
                S_CTRL_W: begin
                    if (op.op_done)
                        state <= op.slave_nack ? S_STOP : S_ADDR;
                end
                S_ADDR: begin
                    if (op.op_done) begin
                        if (op.slave_nack)
                            state <= S_STOP;
                        else
                            state <= read_txn ? S_RSTART : S_DATA;
                    end
                end
                S_DATA: begin
                    if (op.op_done)
                        state <= S_STOP;
                end
                S_RSTART: begin
                    if (op.op_done)
                        state <= S_CTRL_R;
                end
                S_CTRL_R: begin
                    if (op.op_done)
                        state <= op.slave_nack ? S_STOP : S_READ;
                end
                S_READ: begin
                    if (op.op_done)
                        state <= S_STOP;
                end
                S_STOP: begin
                    if (op.op_done)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // request payload
    always_ff @(posedge CLK) begin
        if (accept) begin
            ctrl.fields.dev_code <= `EEPROM_DEV_CODE;
            ctrl.fields.block    <= addr[`EEPROM_ADDR_W-1:8];
            ctrl.fields.rd_flag  <= 1'b0;
            word_addr            <= addr[7:0];
            data                 <= wdata;
        end else if (state == S_RSTART && op.op_done) begin
            ctrl.fields.rd_flag <= 1'b1;  // same block, now reading
        end
    end

endmodule

/* design/i2c_op_if.sv */
`timescale 1ns/1ps

interface i2c_op_if
    import eeprom_pkg::*;
();

    logic    op_valid;
    i2c_op_e op;
    byte_t   tx_byte;
    logic    send_nack;     // answer a read byte with no-ack
    logic    op_ready;
    logic    op_done;       // one cycle at end of op
    logic    slave_nack;    // valid with op_done of a write
    logic    rx_bit;
    logic    rx_bit_valid;

    modport seq (
        output op_valid, op, tx_byte, send_nack,
        input  op_ready, op_done, slave_nack
    );

    modport eng (
        input  op_valid, op, tx_byte, send_nack,
        output op_ready, op_done, slave_nack, rx_bit, rx_bit_valid
    );

    modport res (
        input op_done, slave_nack, rx_bit, rx_bit_valid
    );

endinterface

/* design/eeprom_pkg.sv */
`include "eeprom_macros.svh"

package eeprom_pkg;

    typedef logic [`EEPROM_ADDR_W-1:0] addr_t;  // block bits on top of the word address

    typedef logic [7:0] byte_t;

    // bus operations handed from the sequencer to the engine
    // op_start on an active bus is a repeated start
    typedef enum logic [1:0] {
        op_start,
        op_write,
        op_read,
        op_stop
    } i2c_op_e;

    typedef struct packed {
        logic [3:0] dev_code;
        logic [2:0] block;
        logic       rd_flag;  // 1 = read
    } ctrl_fields_t;

    // control byte, shifted as raw, built and decoded as fields
    typedef union packed {
        byte_t        raw;
        ctrl_fields_t fields;
    } ctrl_byte_u;

endpackage

/* design/eeprom_macros.svh */
`ifndef EEPROM_MACROS_SVH
`define EEPROM_MACROS_SVH

// fixed upper nibble of the control byte
`define EEPROM_DEV_CODE 4'b1010

// request address: 3 block bits over 8 word bits
`define EEPROM_ADDR_W 11

// CLK cycles per quarter of an SCL bit period
// a full bit is four quarters
`define QUARTER_CYCLES 2

`endif
